/* exec_pkg.sv */
// shared widths, vector typedefs and localparams for the execute stage
// enums for operations, csr ops, privilege and trap causes
// packed structs passed between the execute units
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int BYTE_LANES = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // link increments, full and compressed
    localparam word_t INSN_STEP  = 32'd4;
    localparam word_t CINSN_STEP = 32'd2;

    // csr[11:10] == 2'b11 marks a read-only register
    localparam logic [1:0] CSR_RO_PREFIX = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////////////////////

    // NOP must stay at zero, reset value of the wb slot
    typedef enum logic [5:0] {
        NOP, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {NONE, WRITE, SET, CLEAR} csr_op_e;

    // riscv privilege encodings
    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } priv_e;

    // mcause exception codes, NE when nothing is pending
    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ACCESS_FAULT              = 5'd5,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_MMODE               = 5'd11,
        NE                             = 5'h1f
    } exc_code_e;

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        op_e       op;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     second_operand;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic      compressed;
        csr_addr_t csr_addr;
        word_t     jump_imm_target;
    } ex_req_t;

    typedef struct packed {
        logic illegal_inst;
        logic misaligned_fetch;
        logic inst_access_fault;
        logic load_access_fault;
    } exc_flags_t;

    typedef struct packed {
        word_t sum;
        word_t result;
        logic  equal;
        logic  lt;
        logic  ltu;
    } alu_out_t;

    typedef struct packed {
        word_t    address;
        logic     read_en;
        byte_en_t write_en;
        word_t    write_data;
    } mem_req_t;

    typedef struct packed {
        logic    read_en;
        logic    write_en;
        csr_op_e operation;
        word_t   data;
    } csr_req_t;

    typedef struct packed {
        logic      raise;
        exc_code_e code;
        logic      mret;
        logic      int_ack;
    } trap_out_t;

    typedef struct packed {
        logic      write_enable;
        op_e       op;
        word_t     result;
        reg_addr_t rd;
    } wb_t;

endpackage

`default_nettype wire

/* exec_alu.sv */
// integer alu: adders, logic ops, shifts, compares
// result select by decoded operation
`timescale 1ns/10ps
`default_nettype none

module exec_alu (
    input  exec_pkg::ex_req_t  req_i,
    output exec_pkg::alu_out_t alu_o
);
    import exec_pkg::*;

    word_t           sum2_op_a;
    word_t           sum2_op_b;
    word_t           sum2;
    logic [4:0]      shamt;
    logic [XLEN:0]   sub_ext;
    logic            geu;

    // second adder for link value or subtraction
    always_comb begin
        unique case (req_i.op)
            JAL, JALR: begin
                sum2_op_a = req_i.pc;
                sum2_op_b = req_i.compressed ? CINSN_STEP : INSN_STEP;
            end
            SUB: begin
                sum2_op_a = req_i.rs1_data;
                sum2_op_b = -req_i.second_operand;
            end
            default: begin
                sum2_op_a = req_i.rs1_data;
                sum2_op_b = req_i.second_operand;
            end
        endcase
    end

    assign sum2  = sum2_op_a + sum2_op_b;
    assign shamt = req_i.second_operand[4:0];

    // main adder also feeds lsu address and jalr target
    assign alu_o.sum   = req_i.rs1_data + req_i.second_operand;
    assign alu_o.equal = (req_i.rs1_data == req_i.second_operand);
    assign alu_o.lt    = ($signed(req_i.rs1_data) < $signed(req_i.second_operand));
    assign alu_o.ltu   = (req_i.rs1_data < req_i.second_operand);

    // no borrow out of the wide subtraction means rs1 >= operand
    assign sub_ext = {1'b0, req_i.rs1_data} - {1'b0, req_i.second_operand};
    assign geu     = !sub_ext[XLEN];

    always_comb begin
        unique case (req_i.op)
            JAL, JALR, SUB: alu_o.result = sum2;
            SLT:     alu_o.result = {{(XLEN-1){1'b0}}, alu_o.lt};
            SLTU:    alu_o.result = {{(XLEN-1){1'b0}}, alu_o.ltu};
            XOR:     alu_o.result = req_i.rs1_data ^ req_i.second_operand;
            OR:      alu_o.result = req_i.rs1_data | req_i.second_operand;
            AND:     alu_o.result = req_i.rs1_data & req_i.second_operand;
            SLL:     alu_o.result = req_i.rs1_data << shamt;
            SRL:     alu_o.result = req_i.rs1_data >> shamt;
            SRA:     alu_o.result = $signed(req_i.rs1_data) >>> shamt;
            // upper immediate comes in already shifted
            LUI:     alu_o.result = req_i.second_operand;
            AUIPC:   alu_o.result = req_i.jump_imm_target;
            default: alu_o.result = alu_o.sum;
        endcase
    end

    // unsigned compare pair must be exclusive
    always_comb begin
        assert final (!(alu_o.ltu && geu));
    end

endmodule

`default_nettype wire

/* exec_lsu.sv */
// load/store request: aligned address, lane enables, store data
`timescale 1ns/10ps
`default_nettype none

module exec_lsu (
    input  exec_pkg::ex_req_t  req_i,
    input  exec_pkg::alu_out_t alu_i,
    output exec_pkg::mem_req_t mem_o
);
    import exec_pkg::*;

    logic [1:0] offset;

    assign offset = alu_i.sum[1:0];

    // word aligned, lanes select the bytes
    assign mem_o.address = {alu_i.sum[XLEN-1:2], 2'b00};
    assign mem_o.read_en = req_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////////////////////
    // store data
    ////////////////////////////////////////////////////////////////////////////

    // replicate so every lane sees the value
    always_comb begin
        unique case (req_i.op)
            SB:      mem_o.write_data = {BYTE_LANES{req_i.rs2_data[7:0]}};
            SH:      mem_o.write_data = {(BYTE_LANES/2){req_i.rs2_data[15:0]}};
            default: mem_o.write_data = req_i.rs2_data;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // lane enables
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (req_i.op)
            // one lane per byte offset
            SB:      mem_o.write_en = byte_en_t'(1) << offset;
            // upper or lower half by bit 1
            SH:      mem_o.write_en = offset[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.write_en = '1;
            default: mem_o.write_en = '0;
        endcase
    end

    // a request is either a read or a write
    always_comb begin
        assert final (!(mem_o.read_en && (mem_o.write_en != '0)));
    end

endmodule

`default_nettype wire

/* exec_csr.sv */
// csr access: read/write enables, operation, write data
// illegal access check on read-only address and privilege
`timescale 1ns/10ps
`default_nettype none

module exec_csr (
    input  exec_pkg::ex_req_t  req_i,
    input  exec_pkg::priv_e    priv_i,
    output exec_pkg::csr_req_t csr_o,
    output logic               illegal_o
);
    import exec_pkg::*;

    logic       read_en;
    logic       write_en;
    logic [1:0] addr_prefix;
    logic [1:0] addr_priv;

    // csr[11:10] read-only marker, csr[9:8] lowest privilege allowed
    assign addr_prefix = req_i.csr_addr[CSR_ADDR_W-1 -: 2];
    assign addr_priv   = req_i.csr_addr[CSR_ADDR_W-3 -: 2];

    // rw skips the read on x0, set/clear skip the write on x0
    always_comb begin
        unique case (req_i.op)
            CSRRW, CSRRWI: begin
                read_en  = (req_i.rd != '0);
                write_en = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                read_en  = 1'b1;
                write_en = (req_i.rs1 != '0);
            end
            default: begin
                read_en  = 1'b0;
                write_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        unique case (req_i.op)
            CSRRW, CSRRWI: csr_o.operation = WRITE;
            CSRRS, CSRRSI: csr_o.operation = SET;
            CSRRC, CSRRCI: csr_o.operation = CLEAR;
            default:       csr_o.operation = NONE;
        endcase
    end

    // immediate forms carry uimm in the rs1 field
    assign csr_o.data = (req_i.op inside {CSRRW, CSRRS, CSRRC})
                      ? req_i.rs1_data
                      : {{(XLEN-REG_ADDR_W){1'b0}}, req_i.rs1};

    assign illegal_o = (write_en && (addr_prefix == CSR_RO_PREFIX))
                    || ((read_en || write_en) && (addr_priv > priv_i));

    // no side effect on an illegal access
    assign csr_o.read_en  = read_en && !illegal_o;
    assign csr_o.write_en = write_en && !illegal_o;

endmodule

`default_nettype wire

/* exec_trap.sv */
// trap control: exception raise and prioritised cause
// mret and interrupt acknowledge
`timescale 1ns/10ps
`default_nettype none

module exec_trap (
    input  exec_pkg::ex_req_t    req_i,
    input  exec_pkg::exc_flags_t flags_i,
    input  exec_pkg::priv_e      priv_i,
    input  logic                 illegal_csr_i,
    input  exec_pkg::mem_req_t   mem_i,
    input  logic                 interrupt_pending_i,
    output exec_pkg::trap_out_t  trap_o
);
    import exec_pkg::*;

    logic mem_access;
    logic load_fault;

    assign mem_access = mem_i.read_en || (mem_i.write_en != '0);
    // bus fault only counts with a real access
    assign load_fault = flags_i.load_access_fault && mem_access;

    // a bubble never traps
    assign trap_o.raise = (req_i.op != NOP) && (
           flags_i.inst_access_fault
        || flags_i.illegal_inst
        || illegal_csr_i
        || flags_i.misaligned_fetch
        || (req_i.op inside {ECALL, EBREAK})
        || load_fault);

    // highest priority first
    always_comb begin
        if (flags_i.inst_access_fault)
            trap_o.code = INSTRUCTION_ACCESS_FAULT;
        else if (flags_i.illegal_inst || illegal_csr_i)
            trap_o.code = ILLEGAL_INSTRUCTION;
        else if (flags_i.misaligned_fetch)
            trap_o.code = INSTRUCTION_ADDRESS_MISALIGNED;
        else if (req_i.op == ECALL)
            trap_o.code = (priv_i == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        else if (req_i.op == EBREAK)
            trap_o.code = BREAKPOINT;
        else if (load_fault)
            trap_o.code = LOAD_ACCESS_FAULT;
        else
            trap_o.code = NE;
    end

    assign trap_o.mret    = !trap_o.raise && (req_i.op == MRET);
    // interrupt taken on a live instruction only
    assign trap_o.int_ack = interrupt_pending_i && (req_i.op != NOP)
                         && !trap_o.raise && !trap_o.mret;

    always_comb begin
        assert final ($onehot0({trap_o.raise, trap_o.mret, trap_o.int_ack}));
    end

endmodule

`default_nettype wire

/* exec_branch.sv */
// branch decision, jump target, context-switch target
`timescale 1ns/10ps
`default_nettype none

module exec_branch (
    input  exec_pkg::ex_req_t   req_i,
    input  exec_pkg::alu_out_t  alu_i,
    input  exec_pkg::trap_out_t trap_i,
    input  exec_pkg::word_t     mepc_i,
    input  exec_pkg::word_t     mtvec_i,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,
    output logic                ctx_switch_o,
    output exec_pkg::word_t     ctx_switch_target_o
);
    import exec_pkg::*;

    // ge forms are the negated lt flags
    always_comb begin
        unique case (req_i.op)
            BEQ:       jump_o = alu_i.equal;
            BNE:       jump_o = !alu_i.equal;
            BLT:       jump_o = alu_i.lt;
            BLTU:      jump_o = alu_i.ltu;
            BGE:       jump_o = !alu_i.lt;
            BGEU:      jump_o = !alu_i.ltu;
            JAL, JALR: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    // jalr clears bit 0, all others use decode's target
    assign jump_target_o = (req_i.op == JALR)
                         ? {alu_i.sum[XLEN-1:1], 1'b0}
                         : req_i.jump_imm_target;

    // mret wins, then trap entry, then plain jump
    always_comb begin
        if (trap_i.mret)
            ctx_switch_target_o = mepc_i;
        else if (trap_i.raise || trap_i.int_ack)
            ctx_switch_target_o = mtvec_i;
        else
            ctx_switch_target_o = jump_target_o;
    end

    assign ctx_switch_o = trap_i.mret || trap_i.raise || trap_i.int_ack || jump_o;

endmodule

`default_nettype wire

/* exec_writeback.sv */
// writeback result select and write enable
// stage output register, frozen under stall, plus forwarding copy
`timescale 1ns/10ps
`default_nettype none

module exec_writeback (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  exec_pkg::ex_req_t   req_i,
    input  exec_pkg::alu_out_t  alu_i,
    input  exec_pkg::word_t     csr_rdata_i,
    input  exec_pkg::trap_out_t trap_i,
    output exec_pkg::wb_t       wb_o,
    output exec_pkg::wb_t       wb_fwd_o
);
    import exec_pkg::*;

    logic is_csr;
    logic no_write;

    assign is_csr   = req_i.op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
    // bubbles, stores and branches have no rd
    assign no_write = req_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU};

    ////////////////////////////////////////////////////////////////////////////
    // unregistered value, also the forwarding path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wb_fwd_o.op           = req_i.op;
        wb_fwd_o.rd           = req_i.rd;
        wb_fwd_o.result       = is_csr ? csr_rdata_i : alu_i.result;
        // trapped instructions must not retire
        wb_fwd_o.write_enable = !no_write && (req_i.rd != '0) && !trap_i.raise;
    end

    ////////////////////////////////////////////////////////////////////////////
    // wb slot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o <= '{write_enable: 1'b0, op: NOP, result: '0, rd: '0};
        end
        else if (!stall_i) begin
            wb_o <= wb_fwd_o;
        end
    end

    // x0 is never written through the slot
    a_wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (!reset_n)
        wb_o.write_enable |-> (wb_o.rd != '0)
    );

endmodule

`default_nettype wire

/* exec_stage.sv */
// execute stage top: alu, lsu, csr, trap, branch and writeback units
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 stall_i,
    input  exec_pkg::ex_req_t    req_i,
    input  exec_pkg::exc_flags_t flags_i,
    input  exec_pkg::priv_e      priv_i,
    input  exec_pkg::word_t      csr_rdata_i,
    input  logic                 interrupt_pending_i,
    input  exec_pkg::word_t      mepc_i,
    input  exec_pkg::word_t      mtvec_i,
    output exec_pkg::mem_req_t   mem_o,
    output exec_pkg::csr_req_t   csr_o,
    output exec_pkg::trap_out_t  trap_o,
    output logic                 jump_o,
    output exec_pkg::word_t      jump_target_o,
    output logic                 ctx_switch_o,
    output exec_pkg::word_t      ctx_switch_target_o,
    output exec_pkg::wb_t        wb_o,
    output exec_pkg::wb_t        wb_fwd_o
);
    import exec_pkg::*;

    alu_out_t alu;
    logic     illegal_csr;

    exec_alu u_alu (.req_i(req_i), .alu_o(alu));

    exec_lsu u_lsu (.req_i(req_i), .alu_i(alu), .mem_o(mem_o));

    exec_csr u_csr (.req_i(req_i), .priv_i(priv_i), .csr_o(csr_o), .illegal_o(illegal_csr));

    // trap sees the lsu request for the load fault check
    exec_trap u_trap (
        .req_i(req_i), .flags_i(flags_i), .priv_i(priv_i),
        .illegal_csr_i(illegal_csr), .mem_i(mem_o),
        .interrupt_pending_i(interrupt_pending_i), .trap_o(trap_o)
    );

    exec_branch u_branch (
        .req_i(req_i), .alu_i(alu), .trap_i(trap_o),
        .mepc_i(mepc_i), .mtvec_i(mtvec_i),
        .jump_o(jump_o), .jump_target_o(jump_target_o),
        .ctx_switch_o(ctx_switch_o), .ctx_switch_target_o(ctx_switch_target_o)
    );

    exec_writeback u_writeback (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i),
        .req_i(req_i), .alu_i(alu), .csr_rdata_i(csr_rdata_i), .trap_i(trap_o),
        .wb_o(wb_o), .wb_fwd_o(wb_fwd_o)
    );

endmodule

`default_nettype wire

/* tb_exec_stage.sv */
// testbench for the execute stage
// clock, reset, random instruction stream with random stall
// reference model and concurrent checks on every stage output
`timescale 1ns/10ps
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    localparam int N_INSNS    = 400;
    // one cycle per instruction plus reset, five times over
    localparam int MAX_CYCLES = (N_INSNS + 10) * 5;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       stall;
    ex_req_t    req;
    exc_flags_t flags;
    priv_e      priv;
    word_t      csr_rdata;
    logic       int_pend;
    word_t      mepc;
    word_t      mtvec;
    mem_req_t   mem;
    csr_req_t   csr;
    trap_out_t  trap;
    logic       jump;
    word_t      jump_target;
    logic       ctx_switch;
    word_t      ctx_target;
    wb_t        wb;
    wb_t        wb_fwd;

    // reference model
    word_t      exp_sum;
    word_t      exp_result;
    mem_req_t   exp_mem;
    logic       mem_access;
    logic       csr_rd;
    logic       csr_wr;
    logic       exp_illegal;
    csr_req_t   exp_csr;
    trap_out_t  exp_trap;
    logic       exp_jump;
    word_t      exp_target;
    logic       exp_ctx;
    word_t      exp_ctx_target;
    wb_t        exp_fwd;
    wb_t        exp_wb;

    int value_errors = 0;
    int other_errors = 0;
    int cycles       = 0;

    always #2 clk = ~clk;

    exec_stage dut_i (
        .clk(clk), .reset_n(reset_n), .stall_i(stall), .req_i(req), .flags_i(flags),
        .priv_i(priv), .csr_rdata_i(csr_rdata), .interrupt_pending_i(int_pend),
        .mepc_i(mepc), .mtvec_i(mtvec), .mem_o(mem), .csr_o(csr), .trap_o(trap),
        .jump_o(jump), .jump_target_o(jump_target), .ctx_switch_o(ctx_switch),
        .ctx_switch_target_o(ctx_target), .wb_o(wb), .wb_fwd_o(wb_fwd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        exp_sum = req.rs1_data + req.second_operand;
        case (req.op)
            SUB:       exp_result = req.rs1_data - req.second_operand;
            SLT:       exp_result = {31'b0, $signed(req.rs1_data) < $signed(req.second_operand)};
            SLTU:      exp_result = {31'b0, req.rs1_data < req.second_operand};
            XOR:       exp_result = req.rs1_data ^ req.second_operand;
            OR:        exp_result = req.rs1_data | req.second_operand;
            AND:       exp_result = req.rs1_data & req.second_operand;
            SLL:       exp_result = req.rs1_data << req.second_operand[4:0];
            SRL:       exp_result = req.rs1_data >> req.second_operand[4:0];
            SRA:       exp_result = $signed(req.rs1_data) >>> req.second_operand[4:0];
            LUI:       exp_result = req.second_operand;
            AUIPC:     exp_result = req.jump_imm_target;
            // link value, next instruction
            JAL, JALR: exp_result = req.pc + (req.compressed ? 32'd2 : 32'd4);
            default:   exp_result = exp_sum;
        endcase

        // memory request
        exp_mem.address    = {exp_sum[31:2], 2'b00};
        exp_mem.read_en    = req.op inside {LB, LBU, LH, LHU, LW};
        exp_mem.write_en   = 4'b0000;
        exp_mem.write_data = req.rs2_data;
        if (req.op == SB) begin
            exp_mem.write_en   = 4'b0001 << exp_sum[1:0];
            exp_mem.write_data = {4{req.rs2_data[7:0]}};
        end
        else if (req.op == SH) begin
            exp_mem.write_en   = exp_sum[1] ? 4'b1100 : 4'b0011;
            exp_mem.write_data = {2{req.rs2_data[15:0]}};
        end
        else if (req.op == SW) begin
            exp_mem.write_en = 4'b1111;
        end
        mem_access = exp_mem.read_en || (exp_mem.write_en != 4'b0000);

        // csr access rules
        csr_rd = (req.op inside {CSRRS, CSRRC, CSRRSI, CSRRCI})
              || ((req.op inside {CSRRW, CSRRWI}) && (req.rd != '0));
        csr_wr = (req.op inside {CSRRW, CSRRWI})
              || ((req.op inside {CSRRS, CSRRC, CSRRSI, CSRRCI}) && (req.rs1 != '0));
        exp_illegal = (csr_wr && (req.csr_addr[11:10] == 2'b11))
                   || ((csr_rd || csr_wr) && (req.csr_addr[9:8] > priv));
        exp_csr.read_en   = csr_rd && !exp_illegal;
        exp_csr.write_en  = csr_wr && !exp_illegal;
        exp_csr.operation = (req.op inside {CSRRW, CSRRWI}) ? WRITE
                          : (req.op inside {CSRRS, CSRRSI}) ? SET
                          : (req.op inside {CSRRC, CSRRCI}) ? CLEAR : NONE;
        exp_csr.data      = (req.op inside {CSRRW, CSRRS, CSRRC}) ? req.rs1_data
                          : {27'b0, req.rs1};

        // traps, priority order
        exp_trap.raise = (req.op != NOP) && (flags.inst_access_fault || flags.illegal_inst
            || exp_illegal || flags.misaligned_fetch || (req.op inside {ECALL, EBREAK})
            || (flags.load_access_fault && mem_access));
        if (flags.inst_access_fault)
            exp_trap.code = INSTRUCTION_ACCESS_FAULT;
        else if (flags.illegal_inst || exp_illegal)
            exp_trap.code = ILLEGAL_INSTRUCTION;
        else if (flags.misaligned_fetch)
            exp_trap.code = INSTRUCTION_ADDRESS_MISALIGNED;
        else if (req.op == ECALL)
            exp_trap.code = (priv == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        else if (req.op == EBREAK)
            exp_trap.code = BREAKPOINT;
        else if (flags.load_access_fault && mem_access)
            exp_trap.code = LOAD_ACCESS_FAULT;
        else
            exp_trap.code = NE;
        exp_trap.mret    = (req.op == MRET) && !exp_trap.raise;
        exp_trap.int_ack = int_pend && (req.op != NOP) && !exp_trap.raise && !exp_trap.mret;

        // branches and jumps
        case (req.op)
            BEQ:       exp_jump = req.rs1_data == req.second_operand;
            BNE:       exp_jump = req.rs1_data != req.second_operand;
            BLT:       exp_jump = $signed(req.rs1_data) < $signed(req.second_operand);
            BGE:       exp_jump = $signed(req.rs1_data) >= $signed(req.second_operand);
            BLTU:      exp_jump = req.rs1_data < req.second_operand;
            BGEU:      exp_jump = req.rs1_data >= req.second_operand;
            JAL, JALR: exp_jump = 1'b1;
            default:   exp_jump = 1'b0;
        endcase
        exp_target     = (req.op == JALR) ? {exp_sum[31:1], 1'b0} : req.jump_imm_target;
        exp_ctx        = exp_jump || exp_trap.raise || exp_trap.mret || exp_trap.int_ack;
        exp_ctx_target = exp_trap.mret ? mepc
                       : (exp_trap.raise || exp_trap.int_ack) ? mtvec : exp_target;

        // writeback value
        exp_fwd.op           = req.op;
        exp_fwd.rd           = req.rd;
        exp_fwd.result       = (req.op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI})
                             ? csr_rdata : exp_result;
        exp_fwd.write_enable = !(req.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
                            && (req.rd != '0) && !exp_trap.raise;
    end

    // expected wb slot, all zero is NOP with no write
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            exp_wb <= '0;
        else if (!stall)
            exp_wb <= exp_fwd;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        value_errors++;
        $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, want);
    endtask

    task automatic rule_error(input string what);
        other_errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    a_mem: assert property (@(posedge clk) disable iff (!reset_n) mem == exp_mem)
        else value_error("mem_o", 128'(mem), 128'(exp_mem));
    a_csr: assert property (@(posedge clk) disable iff (!reset_n) csr == exp_csr)
        else value_error("csr_o", 128'(csr), 128'(exp_csr));
    a_trap: assert property (@(posedge clk) disable iff (!reset_n) trap == exp_trap)
        else value_error("trap_o", 128'(trap), 128'(exp_trap));
    a_jump: assert property (@(posedge clk) disable iff (!reset_n) jump == exp_jump)
        else value_error("jump_o", 128'(jump), 128'(exp_jump));
    a_target: assert property (@(posedge clk) disable iff (!reset_n) jump_target == exp_target)
        else value_error("jump_target_o", 128'(jump_target), 128'(exp_target));
    a_ctx: assert property (@(posedge clk) disable iff (!reset_n) ctx_switch == exp_ctx)
        else value_error("ctx_switch_o", 128'(ctx_switch), 128'(exp_ctx));
    a_ctx_target: assert property (@(posedge clk) disable iff (!reset_n)
        ctx_target == exp_ctx_target)
        else value_error("ctx_switch_target_o", 128'(ctx_target), 128'(exp_ctx_target));
    a_fwd: assert property (@(posedge clk) disable iff (!reset_n) wb_fwd == exp_fwd)
        else value_error("wb_fwd_o", 128'(wb_fwd), 128'(exp_fwd));
    // slot sampled away from the active edge
    a_wb: assert property (@(negedge clk) disable iff (!reset_n) wb == exp_wb)
        else value_error("wb_o", 128'(wb), 128'(exp_wb));

    a_align: assert property (@(posedge clk) disable iff (!reset_n) mem.address[1:0] == 2'b00)
        else rule_error("memory address is not word aligned");
    a_jalr_bit0: assert property (@(posedge clk) disable iff (!reset_n)
        (req.op == JALR) |-> !jump_target[0])
        else rule_error("JALR target has bit 0 set");
    a_nop_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        (req.op == NOP) |-> !trap.raise)
        else rule_error("a NOP raised an exception");
    a_we_rd: assert property (@(posedge clk) disable iff (!reset_n)
        wb.write_enable |-> (wb.rd != '0))
        else rule_error("wb_o writes register x0");
    a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        stall |=> $stable(wb))
        else rule_error("wb_o changed while stall_i was high");
    a_reset_value: assert property (@(posedge clk) $rose(reset_n) |-> (wb == '0))
        else value_error("wb_o after reset", 128'($sampled(wb)), 128'(0));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random_insn();
        int p;
        p = $urandom_range(0, 2);
        req.op              = op_e'(6'($urandom_range(0, 37)));
        req.pc              = $urandom;
        req.rs1_data        = $urandom;
        // equal operands now and then so branches go both ways
        req.second_operand  = ($urandom_range(0, 3) == 0) ? req.rs1_data : $urandom;
        req.rs2_data        = $urandom;
        req.rd              = ($urandom_range(0, 3) == 0) ? '0 : reg_addr_t'($urandom);
        req.rs1             = ($urandom_range(0, 3) == 0) ? '0 : reg_addr_t'($urandom);
        req.compressed      = 1'($urandom);
        req.csr_addr        = csr_addr_t'($urandom);
        req.jump_imm_target = $urandom;
        // faults on about a quarter of the stream
        flags     = ($urandom_range(0, 3) == 0) ? exc_flags_t'(4'($urandom)) : '0;
        priv      = (p == 0) ? USER : (p == 1) ? SUPERVISOR : MACHINE;
        int_pend  = ($urandom_range(0, 7) == 0);
        csr_rdata = $urandom;
        mepc      = $urandom;
        mtvec     = $urandom;
        stall     = ($urandom_range(0, 3) == 0);
    endtask

    initial begin
        void'($urandom(22));
        reset_n   = 1'b0;
        stall     = 1'b0;
        req       = '0;
        flags     = '0;
        priv      = MACHINE;
        csr_rdata = '0;
        int_pend  = 1'b0;
        mepc      = '0;
        mtvec     = '0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        repeat (N_INSNS) begin
            drive_random_insn();
            @(negedge clk);
        end
        // let the last slot value reach the negedge check
        stall = 1'b0;
        req   = '0;
        repeat (2) @(negedge clk);
        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
exec_pkg.sv
exec_alu.sv
exec_lsu.sv
exec_csr.sv
exec_trap.sv
exec_branch.sv
exec_writeback.sv
exec_stage.sv
tb_exec_stage.sv

/* Makefile */
# verilator build and run of the execute stage testbench
SIM := obj_dir/Vtb_exec_stage

.PHONY: all run clean

all: run

$(SIM): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert -j 0 --top-module tb_exec_stage -f compile.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir
